/* verif/tile_l2_vectors.txt */
// phase kind(0 req, 1 snoop) src(0 ic, 1 l1d, 2 ptw) cmd(0 rd, 1 wr) addr tag data byte_en
// all fields hex, line index is addr[6:3]
0 1 0 0 008 0 0000000000000000 00
0 1 0 0 078 0 0000000000000000 00
1 0 1 1 010 3 1122334455667788 ff
1 0 1 1 010 4 aabbccddeeff0011 0f
1 0 1 0 010 5 0000000000000000 00
1 0 1 0 050 6 0000000000000000 00
2 0 0 1 020 1 0123456789abcdef ff
2 0 1 1 020 2 ffffffffffffffff 81
2 0 2 0 020 3 0000000000000000 00
2 0 0 0 010 4 0000000000000000 00
2 0 1 1 038 7 cafebabedeadbeef 3c
2 0 2 1 440 8 0000111122223333 f0
2 0 2 0 038 9 0000000000000000 00
3 0 0 1 048 a 5555aaaa5555aaaa ff
3 0 1 0 048 b 0000000000000000 00
3 0 2 1 048 c 1234123412341234 0c
3 0 0 0 040 d 0000000000000000 00
3 0 1 1 008 e 0f0f0f0f0f0f0f0f ff
3 0 2 0 020 f 0000000000000000 00
3 0 0 0 048 0 0000000000000000 00
3 0 1 0 008 1 0000000000000000 00
4 1 0 0 010 0 0000000000000000 00
4 1 0 0 048 0 0000000000000000 00
4 1 0 0 008 0 0000000000000000 00
4 1 0 0 070 0 0000000000000000 00

/* compile.f */
+incdir+logic
logic/tile_pkg.sv
logic/l2_req_arbiter.sv
logic/l2_line_store.sv
logic/l2_resp_router.sv
logic/tile_l2_wrapper.sv
verif/tb_tile_l2.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_tile_l2 -Mdir obj_dir -f compile.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_tile_l2)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* verif/tb_tile_l2.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module tb_tile_l2;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_VEC    = 64;
  localparam int TIMEOUT    = 400;

  logic                 clk;
  logic                 reset;

  logic [2:0]           req_valid;
  tile_pkg::mem_cmd_t   req_cmd  [3];
  logic [`PADDR_W-1:0]  req_addr [3];
  logic [`LTAG_W-1:0]   req_tag  [3];
  logic [`DATA_W-1:0]   req_data [3];
  logic [`BE_W-1:0]     req_be   [3];
  logic [2:0]           resp_ready;
  wire  [2:0]           req_ready;
  wire  [2:0]           resp_valid;
  wire  [`LTAG_W-1:0]   resp_tag  [3];
  wire  [`DATA_W-1:0]   resp_data [3];

  logic                 snoop_valid;
  logic [`PADDR_W-1:0]  snoop_paddr;
  wire                  snoop_resp_valid;
  wire  [`DATA_W-1:0]   snoop_resp_data;
  wire  [`BE_W-1:0]     snoop_resp_be;

  // Vectors as read from the data file
  int                   vec_cnt;
  int                   v_phase [MAX_VEC];
  int                   v_kind  [MAX_VEC];
  int                   v_src   [MAX_VEC];
  int                   v_cmd   [MAX_VEC];
  logic [`PADDR_W-1:0]  v_addr  [MAX_VEC];
  logic [`LTAG_W-1:0]   v_tag   [MAX_VEC];
  logic [`DATA_W-1:0]   v_data  [MAX_VEC];
  logic [`BE_W-1:0]     v_be    [MAX_VEC];

  // Reference model and per-source bookkeeping
  logic [`DATA_W-1:0]   model_line [`LINE_CNT];
  logic [`LINE_CNT-1:0] model_written;
  int                   pend_q     [3][$];
  logic [`LTAG_W-1:0]   exp_tag_q  [3][$];
  logic [`DATA_W-1:0]   exp_data_q [3][$];
  int                   exp_cyc_q  [3][$];

  int                   cycle;
  int                   val_errs;
  int                   proto_errs;
  logic [31:0]          rng_state;
  bit                   check_latency;
  bit                   backpressure;
  bit                   aborted;
  string                test_name;

  always #(CLK_PERIOD / 2) clk = ~clk;

  tile_l2_wrapper dut (
    .i_clk              (clk),
    .i_reset            (reset),
    .i_ic_req_valid     (req_valid[0]),
    .i_ic_req_cmd       (req_cmd[0]),
    .i_ic_req_addr      (req_addr[0]),
    .i_ic_req_tag       (req_tag[0]),
    .i_ic_req_data      (req_data[0]),
    .i_ic_req_byte_en   (req_be[0]),
    .o_ic_req_ready     (req_ready[0]),
    .o_ic_resp_valid    (resp_valid[0]),
    .o_ic_resp_tag      (resp_tag[0]),
    .o_ic_resp_data     (resp_data[0]),
    .i_ic_resp_ready    (resp_ready[0]),
    .i_l1d_req_valid    (req_valid[1]),
    .i_l1d_req_cmd      (req_cmd[1]),
    .i_l1d_req_addr     (req_addr[1]),
    .i_l1d_req_tag      (req_tag[1]),
    .i_l1d_req_data     (req_data[1]),
    .i_l1d_req_byte_en  (req_be[1]),
    .o_l1d_req_ready    (req_ready[1]),
    .o_l1d_resp_valid   (resp_valid[1]),
    .o_l1d_resp_tag     (resp_tag[1]),
    .o_l1d_resp_data    (resp_data[1]),
    .i_l1d_resp_ready   (resp_ready[1]),
    .i_ptw_req_valid    (req_valid[2]),
    .i_ptw_req_cmd      (req_cmd[2]),
    .i_ptw_req_addr     (req_addr[2]),
    .i_ptw_req_tag      (req_tag[2]),
    .i_ptw_req_data     (req_data[2]),
    .i_ptw_req_byte_en  (req_be[2]),
    .o_ptw_req_ready    (req_ready[2]),
    .o_ptw_resp_valid   (resp_valid[2]),
    .o_ptw_resp_tag     (resp_tag[2]),
    .o_ptw_resp_data    (resp_data[2]),
    .i_ptw_resp_ready   (resp_ready[2]),
    .i_snoop_req_valid  (snoop_valid),
    .i_snoop_req_paddr  (snoop_paddr),
    .o_snoop_resp_valid (snoop_resp_valid),
    .o_snoop_resp_data  (snoop_resp_data),
    .o_snoop_resp_be    (snoop_resp_be)
  );

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte enables widened to a bit mask over the line
  function automatic logic [`DATA_W-1:0] merge_bytes(logic [`DATA_W-1:0] old_line,
                                                     logic [`DATA_W-1:0] wdata,
                                                     logic [`BE_W-1:0] be);
    logic [`DATA_W-1:0] mask;
    for (int b = 0; b < `BE_W; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_line & ~mask) | (wdata & mask);
  endfunction

  function automatic int line_of(logic [`PADDR_W-1:0] addr);
    return int'(addr[6:3]);
  endfunction

  function automatic string src_name(int s);
    case (s)
      0:       return "ic";
      1:       return "l1d";
      default: return "ptw";
    endcase
  endfunction

  function automatic bit work_left();
    for (int s = 0; s < 3; s++) begin
      if (pend_q[s].size() != 0 || exp_tag_q[s].size() != 0) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_value(string name, logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_condition(bit cond, string what);
    assert (cond) else begin
      $display("[%0t] %s: %s", $time, test_name, what);
      proto_errs++;
    end
  endtask

  task automatic load_vectors();
    int fd;
    int ph, kd, sr, cm;
    logic [`PADDR_W-1:0] ad;
    logic [`LTAG_W-1:0]  tg;
    logic [`DATA_W-1:0]  dt;
    logic [`BE_W-1:0]    be;
    string line;
    vec_cnt = 0;
    fd = $fopen("verif/tile_l2_vectors.txt", "r");
    if (fd == 0) begin
      check_condition(1'b0, "cannot open verif/tile_l2_vectors.txt");
      aborted = 1'b1;
    end else begin
      while (!$feof(fd) && vec_cnt < MAX_VEC) begin
        // Comment lines fail the scan and are skipped
        if ($fgets(line, fd) > 0 &&
            $sscanf(line, "%h %h %h %h %h %h %h %h", ph, kd, sr, cm, ad, tg, dt, be) == 8) begin
          v_phase[vec_cnt] = ph;
          v_kind[vec_cnt]  = kd;
          v_src[vec_cnt]   = sr;
          v_cmd[vec_cnt]   = cm;
          v_addr[vec_cnt]  = ad;
          v_tag[vec_cnt]   = tg;
          v_data[vec_cnt]  = dt;
          v_be[vec_cnt]    = be;
          vec_cnt++;
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // Request traffic
  // --------------------
  task automatic present_requests();
    int v;
    for (int s = 0; s < 3; s++) begin
      if (pend_q[s].size() > 0) begin
        v            = pend_q[s][0];
        req_valid[s] = 1'b1;
        req_cmd[s]   = (v_cmd[v] == 1) ? tile_pkg::CMD_WR : tile_pkg::CMD_RD;
        req_addr[s]  = v_addr[v];
        req_tag[s]   = v_tag[v];
        req_data[s]  = v_data[v];
        req_be[s]    = v_be[v];
      end else begin
        req_valid[s] = 1'b0;
      end
    end
  endtask

  // Model follows the transfers in the order they are seen
  task automatic accept_request(int s);
    int v;
    int idx;
    logic [`DATA_W-1:0] line;
    v    = pend_q[s].pop_front();
    idx  = line_of(v_addr[v]);
    line = model_written[idx] ? model_line[idx] : '0;
    if (v_cmd[v] == 1) begin
      line               = merge_bytes(line, v_data[v], v_be[v]);
      model_line[idx]    = line;
      model_written[idx] = 1'b1;
    end
    exp_tag_q[s].push_back(v_tag[v]);
    exp_data_q[s].push_back(line);
    exp_cyc_q[s].push_back(cycle);
  endtask

  task automatic take_response(int s);
    logic [`LTAG_W-1:0] exp_tag;
    logic [`DATA_W-1:0] exp_data;
    int                 t0;
    if (exp_tag_q[s].size() == 0) begin
      check_condition(1'b0, $sformatf("response on %s with nothing outstanding", src_name(s)));
    end else begin
      exp_tag  = exp_tag_q[s].pop_front();
      exp_data = exp_data_q[s].pop_front();
      t0       = exp_cyc_q[s].pop_front();
      check_value($sformatf("%s %s tag", test_name, src_name(s)), 64'(exp_tag),
                  64'(resp_tag[s]));
      check_value($sformatf("%s %s data", test_name, src_name(s)), exp_data, resp_data[s]);
      if (check_latency) begin
        check_value($sformatf("%s %s latency", test_name, src_name(s)), 64'(2),
                    64'(cycle - t0));
      end
    end
  endtask

  // Drive on the falling edge and sample halfway to the rising edge
  task automatic run_cycle();
    int fired;
    @(negedge clk);
    cycle++;
    present_requests();
    for (int s = 0; s < 3; s++) begin
      rng_state     = xorshift32(rng_state);
      resp_ready[s] = backpressure ? (rng_state[1:0] != 2'b00) : 1'b1;
    end
    #2;
    fired = 0;
    for (int s = 0; s < 3; s++) begin
      if (req_valid[s] && req_ready[s]) begin
        fired++;
        accept_request(s);
      end
    end
    check_condition(fired <= 1, "more than one request accepted in one cycle");
    check_condition($countones(resp_valid) <= 1, "responses on several channels at once");
    for (int s = 0; s < 3; s++) begin
      if (resp_valid[s] && resp_ready[s]) take_response(s);
    end
  endtask

  task automatic run_phase(int ph, string name);
    int waited;
    test_name = name;
    for (int v = 0; v < vec_cnt; v++) begin
      if (v_phase[v] == ph && v_kind[v] == 0) pend_q[v_src[v]].push_back(v);
    end
    waited = 0;
    while (work_left() && waited < TIMEOUT) begin
      run_cycle();
      waited++;
    end
    if (work_left()) begin
      check_condition(1'b0, "timed out with requests or responses still outstanding");
      aborted = 1'b1;
    end
  endtask

  // --------------------
  // Snoops
  // --------------------
  task automatic run_snoops(int ph, string name);
    int idx;
    logic [`DATA_W-1:0] exp_data;
    logic [`BE_W-1:0]   exp_be;
    test_name = name;
    for (int v = 0; v < vec_cnt; v++) begin
      if (v_phase[v] == ph && v_kind[v] == 1) begin
        idx      = line_of(v_addr[v]);
        exp_data = model_written[idx] ? model_line[idx] : '0;
        exp_be   = model_written[idx] ? '1 : '0;
        @(negedge clk);
        snoop_valid = 1'b1;
        snoop_paddr = v_addr[v];
        #2;
        check_condition(!snoop_resp_valid, "snoop response before the strobe was taken");
        @(negedge clk);
        snoop_valid = 1'b0;
        #2;
        check_condition(snoop_resp_valid, "no snoop response one cycle after the strobe");
        check_value($sformatf("%s data", name), exp_data, snoop_resp_data);
        check_value($sformatf("%s be", name), 64'(exp_be), 64'(snoop_resp_be));
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    req_valid     = '0;
    resp_ready    = 3'b111;
    snoop_valid   = 1'b0;
    snoop_paddr   = '0;
    for (int s = 0; s < 3; s++) begin
      req_cmd[s]  = tile_pkg::CMD_RD;
      req_addr[s] = '0;
      req_tag[s]  = '0;
      req_data[s] = '0;
      req_be[s]   = '0;
    end
    model_written = '0;
    rng_state     = 32'd22767;
    cycle         = 0;
    val_errs      = 0;
    proto_errs    = 0;
    check_latency = 1'b0;
    backpressure  = 1'b0;
    aborted       = 1'b0;
    test_name     = "idle_after_reset";

    load_vectors();
    repeat (8) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      #2;
      check_condition(req_ready == 3'b000 && resp_valid == 3'b000 && !snoop_resp_valid,
                      "ready or valid output high while idle after reset");
    end

    if (!aborted) run_snoops(0, "snoop_after_reset");
    check_latency = 1'b1;
    if (!aborted) run_phase(1, "single_source");
    check_latency = 1'b0;
    if (!aborted) run_phase(2, "all_sources");
    backpressure = 1'b1;
    if (!aborted) run_phase(3, "backpressure");
    backpressure = 1'b0;
    resp_ready   = 3'b111;
    if (!aborted) run_snoops(4, "snoop_after_writes");

    $display("errors: %0d value mismatches, %0d other failures", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* logic/tile_l2_wrapper.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module tile_l2_wrapper (
  input  logic                      i_clk,
  input  logic                      i_reset,

  // Instruction fetch
  input  logic                      i_ic_req_valid,
  input  tile_pkg::mem_cmd_t        i_ic_req_cmd,
  input  logic [`PADDR_W-1:0]       i_ic_req_addr,
  input  logic [`LTAG_W-1:0]        i_ic_req_tag,
  input  logic [`DATA_W-1:0]        i_ic_req_data,
  input  logic [`BE_W-1:0]          i_ic_req_byte_en,
  output logic                      o_ic_req_ready,
  output logic                      o_ic_resp_valid,
  output logic [`LTAG_W-1:0]        o_ic_resp_tag,
  output logic [`DATA_W-1:0]        o_ic_resp_data,
  input  logic                      i_ic_resp_ready,

  // L1 data
  input  logic                      i_l1d_req_valid,
  input  tile_pkg::mem_cmd_t        i_l1d_req_cmd,
  input  logic [`PADDR_W-1:0]       i_l1d_req_addr,
  input  logic [`LTAG_W-1:0]        i_l1d_req_tag,
  input  logic [`DATA_W-1:0]        i_l1d_req_data,
  input  logic [`BE_W-1:0]          i_l1d_req_byte_en,
  output logic                      o_l1d_req_ready,
  output logic                      o_l1d_resp_valid,
  output logic [`LTAG_W-1:0]        o_l1d_resp_tag,
  output logic [`DATA_W-1:0]        o_l1d_resp_data,
  input  logic                      i_l1d_resp_ready,

  // Page-table walker
  input  logic                      i_ptw_req_valid,
  input  tile_pkg::mem_cmd_t        i_ptw_req_cmd,
  input  logic [`PADDR_W-1:0]       i_ptw_req_addr,
  input  logic [`LTAG_W-1:0]        i_ptw_req_tag,
  input  logic [`DATA_W-1:0]        i_ptw_req_data,
  input  logic [`BE_W-1:0]          i_ptw_req_byte_en,
  output logic                      o_ptw_req_ready,
  output logic                      o_ptw_resp_valid,
  output logic [`LTAG_W-1:0]        o_ptw_resp_tag,
  output logic [`DATA_W-1:0]        o_ptw_resp_data,
  input  logic                      i_ptw_resp_ready,

  // Snoop
  input  logic                      i_snoop_req_valid,
  input  logic [`PADDR_W-1:0]       i_snoop_req_paddr,
  output logic                      o_snoop_resp_valid,
  output logic [`DATA_W-1:0]        o_snoop_resp_data,
  output logic [`BE_W-1:0]          o_snoop_resp_be
);

  logic                slot_valid;
  logic                slot_ready;
  tile_pkg::mem_cmd_t  slot_cmd;
  logic [`PADDR_W-1:0] slot_addr;
  tile_pkg::l2_tag_u   slot_tag;
  logic [`DATA_W-1:0]  slot_data;
  logic [`BE_W-1:0]    slot_be;

  logic                rsp_valid;
  logic                rsp_ready;
  tile_pkg::l2_tag_u   rsp_tag;
  logic [`DATA_W-1:0]  rsp_data;

  // --------------------
  // Request merge
  // --------------------
  l2_req_arbiter u_l2_req_arbiter (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ic_req_valid    (i_ic_req_valid),
    .i_ic_req_cmd      (i_ic_req_cmd),
    .i_ic_req_addr     (i_ic_req_addr),
    .i_ic_req_tag      (i_ic_req_tag),
    .i_ic_req_data     (i_ic_req_data),
    .i_ic_req_byte_en  (i_ic_req_byte_en),
    .o_ic_req_ready    (o_ic_req_ready),
    .i_l1d_req_valid   (i_l1d_req_valid),
    .i_l1d_req_cmd     (i_l1d_req_cmd),
    .i_l1d_req_addr    (i_l1d_req_addr),
    .i_l1d_req_tag     (i_l1d_req_tag),
    .i_l1d_req_data    (i_l1d_req_data),
    .i_l1d_req_byte_en (i_l1d_req_byte_en),
    .o_l1d_req_ready   (o_l1d_req_ready),
    .i_ptw_req_valid   (i_ptw_req_valid),
    .i_ptw_req_cmd     (i_ptw_req_cmd),
    .i_ptw_req_addr    (i_ptw_req_addr),
    .i_ptw_req_tag     (i_ptw_req_tag),
    .i_ptw_req_data    (i_ptw_req_data),
    .i_ptw_req_byte_en (i_ptw_req_byte_en),
    .o_ptw_req_ready   (o_ptw_req_ready),
    .o_slot_valid      (slot_valid),
    .o_slot_cmd        (slot_cmd),
    .o_slot_addr       (slot_addr),
    .o_slot_tag        (slot_tag),
    .o_slot_data       (slot_data),
    .o_slot_be         (slot_be),
    .i_slot_ready      (slot_ready)
  );

  // --------------------
  // Line store
  // --------------------
  l2_line_store u_l2_line_store (
    .i_clk              (i_clk),
    .i_reset            (i_reset),
    .i_slot_valid       (slot_valid),
    .i_slot_cmd         (slot_cmd),
    .i_slot_addr        (slot_addr),
    .i_slot_tag         (slot_tag),
    .i_slot_data        (slot_data),
    .i_slot_be          (slot_be),
    .o_slot_ready       (slot_ready),
    .o_rsp_valid        (rsp_valid),
    .o_rsp_tag          (rsp_tag),
    .o_rsp_data         (rsp_data),
    .i_rsp_ready        (rsp_ready),
    .i_snoop_req_valid  (i_snoop_req_valid),
    .i_snoop_req_paddr  (i_snoop_req_paddr),
    .o_snoop_resp_valid (o_snoop_resp_valid),
    .o_snoop_resp_data  (o_snoop_resp_data),
    .o_snoop_resp_be    (o_snoop_resp_be)
  );

  // --------------------
  // Response split
  // --------------------
  l2_resp_router u_l2_resp_router (
    .i_rsp_valid      (rsp_valid),
    .i_rsp_tag        (rsp_tag),
    .i_rsp_data       (rsp_data),
    .o_rsp_ready      (rsp_ready),
    .o_ic_resp_valid  (o_ic_resp_valid),
    .o_ic_resp_tag    (o_ic_resp_tag),
    .o_ic_resp_data   (o_ic_resp_data),
    .i_ic_resp_ready  (i_ic_resp_ready),
    .o_l1d_resp_valid (o_l1d_resp_valid),
    .o_l1d_resp_tag   (o_l1d_resp_tag),
    .o_l1d_resp_data  (o_l1d_resp_data),
    .i_l1d_resp_ready (i_l1d_resp_ready),
    .o_ptw_resp_valid (o_ptw_resp_valid),
    .o_ptw_resp_tag   (o_ptw_resp_tag),
    .o_ptw_resp_data  (o_ptw_resp_data),
    .i_ptw_resp_ready (i_ptw_resp_ready)
  );

endmodule

/* logic/l2_resp_router.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module l2_resp_router (
  input  logic                      i_rsp_valid,
  input  tile_pkg::l2_tag_u         i_rsp_tag,
  input  logic [`DATA_W-1:0]        i_rsp_data,
  output logic                      o_rsp_ready,

  output logic                      o_ic_resp_valid,
  output logic [`LTAG_W-1:0]        o_ic_resp_tag,
  output logic [`DATA_W-1:0]        o_ic_resp_data,
  input  logic                      i_ic_resp_ready,

  output logic                      o_l1d_resp_valid,
  output logic [`LTAG_W-1:0]        o_l1d_resp_tag,
  output logic [`DATA_W-1:0]        o_l1d_resp_data,
  input  logic                      i_l1d_resp_ready,

  output logic                      o_ptw_resp_valid,
  output logic [`LTAG_W-1:0]        o_ptw_resp_tag,
  output logic [`DATA_W-1:0]        o_ptw_resp_data,
  input  logic                      i_ptw_resp_ready
);

  tile_pkg::src_id_t dst;

  assign dst = i_rsp_tag.fld.src;

  // Only the addressed source sees valid
  assign o_ic_resp_valid  = i_rsp_valid && (dst == tile_pkg::SRC_IC);
  assign o_l1d_resp_valid = i_rsp_valid && (dst == tile_pkg::SRC_L1D);
  assign o_ptw_resp_valid = i_rsp_valid && (dst == tile_pkg::SRC_PTW);

  // Source number stripped off
  assign o_ic_resp_tag  = i_rsp_tag.fld.ltag;
  assign o_l1d_resp_tag = i_rsp_tag.fld.ltag;
  assign o_ptw_resp_tag = i_rsp_tag.fld.ltag;

  assign o_ic_resp_data  = i_rsp_data;
  assign o_l1d_resp_data = i_rsp_data;
  assign o_ptw_resp_data = i_rsp_data;

  always_comb begin
    case (dst)
      tile_pkg::SRC_IC:  o_rsp_ready = i_ic_resp_ready;
      tile_pkg::SRC_L1D: o_rsp_ready = i_l1d_resp_ready;
      tile_pkg::SRC_PTW: o_rsp_ready = i_ptw_resp_ready;
      default:           o_rsp_ready = 1'b0;
    endcase
  end

  // Tag source comes from the arbiter, which never issues 3
  always_comb begin
    if (i_rsp_valid) begin
      assert (i_rsp_tag.raw[`L2_TAG_W-1 -: `SRC_W] != 2'd3)
        else $error("response tag carries unused source 3");
    end
  end

endmodule

/* logic/l2_line_store.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module l2_line_store (
  input  logic                      i_clk,
  input  logic                      i_reset,

  input  logic                      i_slot_valid,
  input  tile_pkg::mem_cmd_t        i_slot_cmd,
  input  logic [`PADDR_W-1:0]       i_slot_addr,
  input  tile_pkg::l2_tag_u         i_slot_tag,
  input  logic [`DATA_W-1:0]        i_slot_data,
  input  logic [`BE_W-1:0]          i_slot_be,
  output logic                      o_slot_ready,

  output logic                      o_rsp_valid,
  output tile_pkg::l2_tag_u         o_rsp_tag,
  output logic [`DATA_W-1:0]        o_rsp_data,
  input  logic                      i_rsp_ready,

  input  logic                      i_snoop_req_valid,
  input  logic [`PADDR_W-1:0]       i_snoop_req_paddr,
  output logic                      o_snoop_resp_valid,
  output logic [`DATA_W-1:0]        o_snoop_resp_data,
  output logic [`BE_W-1:0]          o_snoop_resp_be
);

  localparam int IDX_W   = $clog2(`LINE_CNT);
  localparam int IDX_LSB = $clog2(`BE_W);

  logic [`DATA_W-1:0]   mem [`LINE_CNT];
  logic [`LINE_CNT-1:0] written_q;

  logic [IDX_W-1:0]     slot_idx;
  logic [IDX_W-1:0]     snoop_idx;
  logic [`DATA_W-1:0]   old_line;
  logic [`DATA_W-1:0]   new_line;
  logic                 slot_fire;
  logic                 slot_wr;

  assign slot_idx  = i_slot_addr[IDX_LSB +: IDX_W];
  assign snoop_idx = i_snoop_req_paddr[IDX_LSB +: IDX_W];

  assign o_slot_ready = !o_rsp_valid || i_rsp_ready;
  assign slot_fire    = i_slot_valid && o_slot_ready;
  assign slot_wr      = slot_fire && (i_slot_cmd == tile_pkg::CMD_WR);

  // Unwritten lines read as zero
  assign old_line = written_q[slot_idx] ? mem[slot_idx] : '0;

  always_comb begin
    new_line = old_line;
    if (i_slot_cmd == tile_pkg::CMD_WR) begin
      for (int b = 0; b < `BE_W; b++) begin
        if (i_slot_be[b]) new_line[b*8 +: 8] = i_slot_data[b*8 +: 8];
      end
    end
  end

  // --------------------
  // Lines and flags
  // --------------------
  always_ff @(posedge i_clk) begin
    if (slot_wr) mem[slot_idx] <= new_line;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      written_q <= '0;
    end else if (slot_wr) begin
      written_q[slot_idx] <= 1'b1;
    end
  end

  // Response register, holds while the router is stalled
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_rsp_valid <= 1'b0;
    end else if (o_slot_ready) begin
      o_rsp_valid <= i_slot_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (slot_fire) begin
      o_rsp_tag.raw <= i_slot_tag.raw;
      o_rsp_data    <= new_line;
    end
  end

  // --------------------
  // Snoop port
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) o_snoop_resp_valid <= 1'b0;
    else o_snoop_resp_valid <= i_snoop_req_valid;
  end

  // Reads the line before any same-cycle write lands
  always_ff @(posedge i_clk) begin
    if (i_snoop_req_valid) begin
      o_snoop_resp_be   <= {`BE_W{written_q[snoop_idx]}};
      o_snoop_resp_data <= written_q[snoop_idx] ? mem[snoop_idx] : '0;
    end
  end

  a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    o_rsp_valid && !i_rsp_ready |=>
      o_rsp_valid && $stable(o_rsp_tag) && $stable(o_rsp_data))
    else $error("response changed while stalled");

endmodule

/* logic/l2_req_arbiter.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module l2_req_arbiter (
  input  logic                      i_clk,
  input  logic                      i_reset,

  input  logic                      i_ic_req_valid,
  input  tile_pkg::mem_cmd_t        i_ic_req_cmd,
  input  logic [`PADDR_W-1:0]       i_ic_req_addr,
  input  logic [`LTAG_W-1:0]        i_ic_req_tag,
  input  logic [`DATA_W-1:0]        i_ic_req_data,
  input  logic [`BE_W-1:0]          i_ic_req_byte_en,
  output logic                      o_ic_req_ready,

  input  logic                      i_l1d_req_valid,
  input  tile_pkg::mem_cmd_t        i_l1d_req_cmd,
  input  logic [`PADDR_W-1:0]       i_l1d_req_addr,
  input  logic [`LTAG_W-1:0]        i_l1d_req_tag,
  input  logic [`DATA_W-1:0]        i_l1d_req_data,
  input  logic [`BE_W-1:0]          i_l1d_req_byte_en,
  output logic                      o_l1d_req_ready,

  input  logic                      i_ptw_req_valid,
  input  tile_pkg::mem_cmd_t        i_ptw_req_cmd,
  input  logic [`PADDR_W-1:0]       i_ptw_req_addr,
  input  logic [`LTAG_W-1:0]        i_ptw_req_tag,
  input  logic [`DATA_W-1:0]        i_ptw_req_data,
  input  logic [`BE_W-1:0]          i_ptw_req_byte_en,
  output logic                      o_ptw_req_ready,

  output logic                      o_slot_valid,
  output tile_pkg::mem_cmd_t        o_slot_cmd,
  output logic [`PADDR_W-1:0]       o_slot_addr,
  output tile_pkg::l2_tag_u         o_slot_tag,
  output logic [`DATA_W-1:0]        o_slot_data,
  output logic [`BE_W-1:0]          o_slot_be,
  input  logic                      i_slot_ready
);

  logic [2:0]          req_valid;
  tile_pkg::mem_cmd_t  req_cmd  [3];
  logic [`PADDR_W-1:0] req_addr [3];
  logic [`LTAG_W-1:0]  req_ltag [3];
  logic [`DATA_W-1:0]  req_data [3];
  logic [`BE_W-1:0]    req_be   [3];

  logic [2:0]          grant;
  logic [1:0]          win_idx;
  logic [1:0]          last_q;
  logic                can_load;
  logic                xfer;
  tile_pkg::l2_tag_u   win_tag;

  assign req_valid = {i_ptw_req_valid, i_l1d_req_valid, i_ic_req_valid};
  assign req_cmd   = '{i_ic_req_cmd, i_l1d_req_cmd, i_ptw_req_cmd};
  assign req_addr  = '{i_ic_req_addr, i_l1d_req_addr, i_ptw_req_addr};
  assign req_ltag  = '{i_ic_req_tag, i_l1d_req_tag, i_ptw_req_tag};
  assign req_data  = '{i_ic_req_data, i_l1d_req_data, i_ptw_req_data};
  assign req_be    = '{i_ic_req_byte_en, i_l1d_req_byte_en, i_ptw_req_byte_en};

  // Search starts one past the last winner
  always_comb begin
    int cand;
    grant   = '0;
    win_idx = '0;
    for (int i = 1; i <= 3; i++) begin
      cand = (int'(last_q) + i) % 3;
      if (grant == '0 && req_valid[cand]) begin
        grant[cand] = 1'b1;
        win_idx     = 2'(cand);
      end
    end
  end

  assign can_load = !o_slot_valid || i_slot_ready;
  assign xfer     = (|grant) && can_load;

  assign o_ic_req_ready  = grant[0] && can_load;
  assign o_l1d_req_ready = grant[1] && can_load;
  assign o_ptw_req_ready = grant[2] && can_load;

  always_comb begin
    win_tag.fld.src  = tile_pkg::src_id_t'(win_idx);
    win_tag.fld.ltag = req_ltag[win_idx];
  end

  // --------------------
  // Slot register
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_slot_valid <= 1'b0;
      last_q       <= 2'd2;
    end else begin
      if (can_load) o_slot_valid <= |grant;
      if (xfer) last_q <= win_idx;
    end
  end

  always_ff @(posedge i_clk) begin
    if (xfer) begin
      o_slot_cmd  <= req_cmd[win_idx];
      o_slot_addr <= req_addr[win_idx];
      o_slot_tag  <= win_tag;
      o_slot_data <= req_data[win_idx];
      o_slot_be   <= req_be[win_idx];
    end
  end

  a_one_ready: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({o_ptw_req_ready, o_l1d_req_ready, o_ic_req_ready}))
    else $error("more than one request channel granted");

endmodule

/* logic/tile_pkg.sv */
`include "tile_config.svh"

package tile_pkg;

  // Access command
  typedef enum logic {
    CMD_RD = 1'b0,
    CMD_WR = 1'b1
  } mem_cmd_t;

  // Requesting source, value 3 unused
  typedef enum logic [`SRC_W-1:0] {
    SRC_IC  = 2'd0,
    SRC_L1D = 2'd1,
    SRC_PTW = 2'd2
  } src_id_t;

  // Field view of the widened tag
  typedef struct packed {
    src_id_t             src;
    logic [`LTAG_W-1:0]  ltag;
  } l2_tag_fld_t;

  // Same tag bits, either opaque or split into source and local tag
  typedef union packed {
    logic [`L2_TAG_W-1:0] raw;
    l2_tag_fld_t          fld;
  } l2_tag_u;

endpackage

/* logic/tile_config.svh */
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// --------------------
// Request channels
// --------------------

// Physical address width
`define PADDR_W 12

// Line and data width
`define DATA_W 64
`define BE_W (`DATA_W / 8)

// --------------------
// Line store and tags
// --------------------

// 16 lines, index taken from addr[6:3]
`define LINE_CNT 16

// Source-local tag, source number, and the widened tag
`define LTAG_W 4
`define SRC_W 2
`define L2_TAG_W (`SRC_W + `LTAG_W)

`endif
